/* rtl/mpu_cmd_queue.sv */
// ================================================
// Command FIFO for the SPI frame engine
// Returns one host credit per popped entry
// ================================================
`timescale 1ns/10ps

module mpu_cmd_queue import mpu_spi_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       push,
  input  mpu_frame_u push_frame,
  input  logic       pop,
  output logic       q_valid,
  output mpu_frame_u q_frame,
  output logic       credit_return
);

  // Frame storage
  mpu_frame_u       mem [CMD_DEPTH];

  // Pointers wrap on their own, depth is a power of two
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  // Occupancy, 0 to CMD_DEPTH
  logic [OCC_W-1:0] count;

  // Head of queue straight to engine
  assign q_valid = (count != '0);
  assign q_frame = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_frame;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Slot freed, hand credit back next cycle
      credit_return <= pop;
    end
  end

  // Host credit counter must keep pushes off a full queue
  a_no_push_full: assert property (
    @(posedge clk) disable iff (rst) push |-> (count != OCC_W'(CMD_DEPTH))
  );

  // Engine only pops what is there
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (rst) pop |-> q_valid
  );

endmodule

/* rtl/mpu_spi_config.sv */
// ================================================
// SPI timing config registers
// Run-time sclk half-period and inter-frame gap
// ================================================
`timescale 1ns/10ps

module mpu_spi_config import mpu_spi_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             cfg_we,
  input  logic             cfg_sel,
  input  logic [7:0]       cfg_wdata,
  output logic [DIV_W-1:0] half_period,
  output logic [GAP_W-1:0] gap
);

  // Low bits of write data for divider
  logic [DIV_W-1:0] div_val;

  assign div_val = cfg_wdata[DIV_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      half_period <= DIV_RESET;
      gap         <= GAP_RESET;
    end else if (cfg_we) begin
      case (cfg_sel)
        CFG_DIV: begin
          // Too fast for the edge scheme, hold at minimum
          if (div_val < DIV_MIN) begin
            half_period <= DIV_MIN;
          end else begin
            half_period <= div_val;
          end
        end
        CFG_GAP: begin
          gap <= GAP_W'(cfg_wdata);
        end
      endcase
    end
  end

  // Engine needs at least two cycles per sclk half
  a_div_min: assert property (
    @(posedge clk) disable iff (rst) half_period >= DIV_MIN
  );

endmodule

/* rtl/mpu_spi_pkg.sv */
// ================================================
// MPU9250 SPI master shared definitions
// Frame layout, sizes, config indices and resets
// ================================================
package mpu_spi_pkg;

  // SPI frame and bit counter
  localparam int FRAME_BITS = 16;
  localparam int BIT_CNT_W  = $clog2(FRAME_BITS);

  // Command queue sizing, also initial host credits
  localparam int CMD_DEPTH = 4;
  localparam int PTR_W     = $clog2(CMD_DEPTH);
  localparam int OCC_W     = $clog2(CMD_DEPTH + 1);

  // Timing register widths
  localparam int DIV_W = 4;
  localparam int GAP_W = 8;

  // Config register select
  localparam logic CFG_DIV = 1'b0;
  localparam logic CFG_GAP = 1'b1;

  // Timing values after reset, in clk cycles
  localparam logic [DIV_W-1:0] DIV_RESET = 4'd4;
  localparam logic [DIV_W-1:0] DIV_MIN   = 4'd2;
  localparam logic [GAP_W-1:0] GAP_RESET = 8'd16;

  // Frame engine states
  localparam int              ST_W     = 3;
  localparam logic [ST_W-1:0] ST_IDLE  = 3'd0;
  localparam logic [ST_W-1:0] ST_LEAD  = 3'd1;
  localparam logic [ST_W-1:0] ST_SHIFT = 3'd2;
  localparam logic [ST_W-1:0] ST_TRAIL = 3'd3;
  localparam logic [ST_W-1:0] ST_GAP   = 3'd4;

  // One SPI frame, as command fields or as raw shift word
  typedef union packed {
    struct packed {
      logic       rw;
      logic [6:0] reg_addr;
      logic [7:0] data;
    } fields;
    logic [FRAME_BITS-1:0] raw;
  } mpu_frame_u;

endpackage

/* rtl/mpu_spi_top.sv */
// ================================================
// MPU9250 SPI master top level
// ================================================
`timescale 1ns/10ps

module mpu_spi_top import mpu_spi_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_valid,
  input  mpu_frame_u cmd_frame,
  input  logic       cfg_we,
  input  logic       cfg_sel,
  input  logic [7:0] cfg_wdata,
  input  logic       miso,
  output logic       credit_return,
  output logic       rsp_valid,
  output logic [7:0] rsp_data,
  output logic       sclk,
  output logic       cs_n,
  output logic       mosi
);

  // Queue to engine
  logic             q_valid;
  logic             q_pop;
  mpu_frame_u       q_frame;

  // Config to engine
  logic [DIV_W-1:0] half_period;
  logic [GAP_W-1:0] gap;

  mpu_spi_config mpu_spi_config_i (
    .clk         (clk),
    .rst         (rst),
    .cfg_we      (cfg_we),
    .cfg_sel     (cfg_sel),
    .cfg_wdata   (cfg_wdata),
    .half_period (half_period),
    .gap         (gap)
  );

  // Host pushes are credit limited
  mpu_cmd_queue mpu_cmd_queue_i (
    .clk           (clk),
    .rst           (rst),
    .push          (cmd_valid),
    .push_frame    (cmd_frame),
    .pop           (q_pop),
    .q_valid       (q_valid),
    .q_frame       (q_frame),
    .credit_return (credit_return)
  );

  spi_frame_engine spi_frame_engine_i (
    .clk         (clk),
    .rst         (rst),
    .q_valid     (q_valid),
    .q_frame     (q_frame),
    .half_period (half_period),
    .gap         (gap),
    .miso        (miso),
    .q_pop       (q_pop),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .rsp_valid   (rsp_valid),
    .rsp_data    (rsp_data)
  );

endmodule

/* rtl/spi_frame_engine.sv */
// ================================================
// Mode-3 SPI frame engine for MPU9250
// Shifts 16-bit frames, captures read byte
// ================================================
`timescale 1ns/10ps

module spi_frame_engine import mpu_spi_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             q_valid,
  input  mpu_frame_u       q_frame,
  input  logic [DIV_W-1:0] half_period,
  input  logic [GAP_W-1:0] gap,
  input  logic             miso,
  output logic             q_pop,
  output logic             sclk,
  output logic             cs_n,
  output logic             mosi,
  output logic             rsp_valid,
  output logic [7:0]       rsp_data
);

  logic [ST_W-1:0]      state;
  // Half-period frozen for the whole frame
  logic [DIV_W-1:0]     hp_q;
  logic [DIV_W-1:0]     div_cnt;
  logic [GAP_W-1:0]     gap_cnt;
  // Rising edges seen so far
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic                 rd_q;
  // TX bits leave at the top, MISO enters at the bottom
  mpu_frame_u           shift_q;
  logic                 div_tick;

  // Take a command whenever idle
  assign q_pop    = (state == ST_IDLE) && q_valid;
  assign div_tick = (div_cnt == '0);

  // Last gap cycle carries the response
  assign rsp_valid = (state == ST_GAP) && (gap_cnt <= GAP_W'(1));
  // Captured byte lands in the data field position
  assign rsp_data  = rd_q ? shift_q.fields.data : 8'h00;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      sclk    <= 1'b1;
      cs_n    <= 1'b1;
      mosi    <= 1'b0;
      hp_q    <= DIV_RESET;
      div_cnt <= '0;
      gap_cnt <= '0;
      bit_cnt <= '0;
      rd_q    <= 1'b0;
    end else begin
      // Divider runs through lead, shift and trail
      if (state != ST_IDLE && state != ST_GAP) begin
        div_cnt <= div_tick ? hp_q - 1'b1 : div_cnt - 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (q_valid) begin
            shift_q <= q_frame;
            rd_q    <= q_frame.fields.rw;
            // Sample timing config at pop
            hp_q    <= half_period;
            div_cnt <= half_period - 1'b1;
            gap_cnt <= gap;
            bit_cnt <= '0;
            cs_n    <= 1'b0;
            state   <= ST_LEAD;
          end
        end
        ST_LEAD: begin
          // First falling edge, MSB out
          if (div_tick) begin
            sclk  <= 1'b0;
            mosi  <= shift_q.raw[FRAME_BITS-1];
            state <= ST_SHIFT;
          end
        end
        ST_SHIFT: begin
          if (div_tick) begin
            sclk <= ~sclk;
            if (sclk) begin
              // Falling edge, next bit out
              mosi <= shift_q.raw[FRAME_BITS-1];
            end else begin
              // Rising edge, sample MISO
              shift_q.raw <= {shift_q.raw[FRAME_BITS-2:0], miso};
              bit_cnt     <= bit_cnt + 1'b1;
              if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) begin
                state <= ST_TRAIL;
              end
            end
          end
        end
        ST_TRAIL: begin
          // Half period after last rise, release chip select
          if (div_tick) begin
            cs_n  <= 1'b1;
            mosi  <= 1'b0;
            state <= ST_GAP;
          end
        end
        ST_GAP: begin
          if (gap_cnt <= GAP_W'(1)) begin
            state <= ST_IDLE;
          end else begin
            gap_cnt <= gap_cnt - 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Mode 3 idles with sclk high outside a frame
  a_sclk_idle_high: assert property (
    @(posedge clk) disable iff (rst) cs_n |-> sclk
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the MPU9250 SPI master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module mpu_spi_tb -Mdir obj_dir -f sources.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Vmpu_spi_tb
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi

exit 0

/* sources.f */
rtl/mpu_spi_pkg.sv
rtl/mpu_spi_config.sv
rtl/mpu_cmd_queue.sv
rtl/spi_frame_engine.sv
rtl/mpu_spi_top.sv
tests/mpu_sensor_model.sv
tests/mpu_spi_tb.sv

/* tests/mpu_sensor_model.sv */
// ================================================
// MPU9250 behavioral SPI slave, mode 3
// Register file plus sclk half-period monitor
// ================================================
`timescale 1ns/10ps

module mpu_sensor_model import mpu_spi_pkg::*; (
  input  logic             clk,
  input  logic             sclk,
  input  logic             cs_n,
  input  logic             mosi,
  output logic             miso,
  output logic [DIV_W-1:0] half_meas
);

  logic [7:0]       regs [128];
  // Frame bits as received, MSB first
  logic [15:0]      rx_q      = '0;
  int               bit_cnt   = 0;
  logic             rd_en     = 1'b0;
  // Read byte, shifted out from the top
  logic [7:0]       rd_byte   = '0;
  logic             miso_q    = 1'b0;
  // Period monitor
  logic [7:0]       edge_cnt  = '0;
  logic             sclk_q    = 1'b1;
  logic             have_edge = 1'b0;
  logic [DIV_W-1:0] meas_q    = '0;

  assign miso      = miso_q;
  assign half_meas = meas_q;

  // Register i powers up as i XOR 0xA5
  initial begin
    for (int i = 0; i < 128; i++) begin
      regs[i[6:0]] = i[7:0] ^ 8'hA5;
    end
  end

  // Mode 3, sample MOSI on rising sclk
  always @(posedge sclk) begin
    if (cs_n == 1'b0) begin
      rx_q    = {rx_q[14:0], mosi};
      bit_cnt = bit_cnt + 1;
      // Command byte complete
      if (bit_cnt == 8) begin
        // Addressed register goes out on MISO for writes too
        rd_en   = 1'b1;
        rd_byte = regs[rx_q[6:0]];
      end
      if (bit_cnt == FRAME_BITS) begin
        if (!rx_q[15]) begin
          regs[rx_q[14:8]] = rx_q[7:0];
        end
        bit_cnt = 0;
        rd_en   = 1'b0;
      end
    end
  end

  // Read data changes on falling sclk
  always @(negedge sclk) begin
    if (cs_n == 1'b0) begin
      if (rd_en) begin
        miso_q  = rd_byte[7];
        rd_byte = {rd_byte[6:0], 1'b0};
      end else begin
        miso_q = 1'b0;
      end
    end
  end

  // clk cycles between sclk edges of one frame
  always @(posedge clk) begin
    sclk_q <= sclk;
    if (cs_n) begin
      have_edge <= 1'b0;
    end else if (sclk != sclk_q) begin
      if (have_edge) begin
        meas_q <= edge_cnt[DIV_W-1:0];
      end
      have_edge <= 1'b1;
      edge_cnt  <= 8'd1;
    end else begin
      edge_cnt <= edge_cnt + 8'd1;
    end
  end

endmodule

/* tests/mpu_spi_tb.sv */
// ================================================
// MPU9250 SPI master testbench
// Trace driven host with credits and sensor model
// ================================================
`timescale 1ns/10ps

module mpu_spi_tb import mpu_spi_pkg::*; ();

  // Wait bound in clk cycles
  localparam int TIMEOUT = 20000;

  logic             clk;
  logic             rst;
  logic             cmd_valid;
  mpu_frame_u       cmd_frame;
  logic             cfg_we;
  logic             cfg_sel;
  logic [7:0]       cfg_wdata;
  logic             miso;
  logic             credit_return;
  logic             rsp_valid;
  logic [7:0]       rsp_data;
  logic             sclk;
  logic             cs_n;
  logic             mosi;
  logic [DIV_W-1:0] half_meas;

  // Host side bookkeeping
  int               sent_total = 0;
  int               ret_total  = 0;
  logic [15:0]      lfsr       = 16'd14206;
  // Expected responses in command order
  logic [7:0]       exp_q [$];
  string            name_q [$];

  mpu_spi_top mpu_spi_top_i (
    .clk           (clk),
    .rst           (rst),
    .cmd_valid     (cmd_valid),
    .cmd_frame     (cmd_frame),
    .cfg_we        (cfg_we),
    .cfg_sel       (cfg_sel),
    .cfg_wdata     (cfg_wdata),
    .miso          (miso),
    .credit_return (credit_return),
    .rsp_valid     (rsp_valid),
    .rsp_data      (rsp_data),
    .sclk          (sclk),
    .cs_n          (cs_n),
    .mosi          (mosi)
  );

  mpu_sensor_model mpu_sensor_model_i (
    .clk       (clk),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso),
    .half_meas (half_meas)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_data(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH %s expected %02h actual %02h", name, expected, actual));
    end
  endtask

  task automatic check_cycles(input string name, input logic [DIV_W-1:0] expected,
                              input logic [DIV_W-1:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  task automatic check_credit(input string name, input logic [OCC_W-1:0] expected,
                              input logic [OCC_W-1:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  task automatic check_level(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int credits();
    return CMD_DEPTH - sent_total + ret_total;
  endfunction

  // Returned credits, one per pulse
  always @(posedge clk) begin
    if (!rst && credit_return === 1'b1) begin
      ret_total <= ret_total + 1;
    end
  end

  // Responses must match commands in order
  always @(posedge clk) begin
    if (!rst && rsp_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        fail_run("response arrived with no command outstanding");
      end else begin
        check_data(name_q.pop_front(), exp_q.pop_front(), rsp_data);
      end
    end
  end

  // Three LFSR bits, 0 to 7 idle cycles
  task automatic idle_gap();
    int g;
    g = 0;
    for (int i = 0; i < 3; i++) begin
      lfsr = lfsr_step(lfsr);
      g = (g << 1) | int'(lfsr[0]);
    end
    repeat (g) @(negedge clk);
  endtask

  task automatic wait_credit();
    int t;
    t = 0;
    while (credits() == 0) begin
      if (t >= TIMEOUT) begin
        fail_run("timeout waiting for a command credit");
      end
      @(negedge clk);
      t++;
    end
  endtask

  task automatic wait_full_credit();
    int t;
    t = 0;
    while (credits() != CMD_DEPTH) begin
      if (t >= TIMEOUT) begin
        fail_run("timeout waiting for all credits to return");
      end
      @(negedge clk);
      t++;
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_q.size() != 0) begin
      if (t >= TIMEOUT) begin
        fail_run("timeout waiting for outstanding responses");
      end
      @(negedge clk);
      t++;
    end
  endtask

  // One credit spent per push
  task automatic drive_cmd(input logic rw, input logic [6:0] addr, input logic [7:0] data,
                           input logic [7:0] expected, input string name);
    cmd_frame.fields.rw       = rw;
    cmd_frame.fields.reg_addr = addr;
    cmd_frame.fields.data     = data;
    cmd_valid                 = 1'b1;
    sent_total++;
    exp_q.push_back(expected);
    name_q.push_back(name);
  endtask

  task automatic send_cmd(input logic rw, input logic [6:0] addr, input logic [7:0] data,
                          input logic [7:0] expected, input string name);
    idle_gap();
    wait_credit();
    drive_cmd(rw, addr, data, expected, name);
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  // Back to back writes until credits run out
  task automatic flood(input logic [6:0] addr, input logic [7:0] data);
    wait_full_credit();
    for (int i = 0; i < CMD_DEPTH; i++) begin
      drive_cmd(1'b0, addr + 7'(i), data + 8'(i), 8'h00, $sformatf("flood write %0d", i));
      if (i == CMD_DEPTH - 1) begin
        check_credit("flood credits", '0, OCC_W'(credits()));
      end
      @(negedge clk);
    end
    cmd_valid = 1'b0;
  endtask

  task automatic write_cfg(input logic sel, input logic [7:0] value);
    // Engine idle, so the next frame picks up the new value
    wait_drain();
    cfg_we    = 1'b1;
    cfg_sel   = sel;
    cfg_wdata = value;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  initial begin
    int         fd;
    int         n;
    string      line;
    logic [7:0] op;
    logic [7:0] a;
    logic [7:0] b;
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd_frame = '0;
    cfg_we    = 1'b0;
    cfg_sel   = 1'b0;
    cfg_wdata = 8'h00;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    // Idle bus after reset
    repeat (20) begin
      @(negedge clk);
      check_level("reset sclk", 1'b1, sclk);
      check_level("reset cs_n", 1'b1, cs_n);
      check_level("reset mosi", 1'b0, mosi);
      check_level("reset rsp_valid", 1'b0, rsp_valid);
      check_level("reset credit_return", 1'b0, credit_return);
    end

    fd = $fopen("tests/mpu_spi_trace.txt", "r");
    if (fd == 0) begin
      fail_run("could not open tests/mpu_spi_trace.txt");
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%c %h %h", op, a, b);
      if (n <= 0 || op == "#" || op == "\n") begin
        // Comment or blank line
      end else if (n != 3) begin
        fail_run($sformatf("malformed trace line: %s", line));
      end else begin
        case (op)
          "W": send_cmd(1'b0, a[6:0], b, 8'h00, $sformatf("write %02h", a));
          "R": send_cmd(1'b1, a[6:0], 8'h00, b, $sformatf("read %02h", a));
          "C": write_cfg(a[0], b);
          "F": flood(a[6:0], b);
          "P": begin
            wait_drain();
            check_cycles($sformatf("half period %0d", a), a[DIV_W-1:0], half_meas);
          end
          default: fail_run($sformatf("unknown trace opcode %c", op));
        endcase
      end
    end
    $fclose(fd);

    wait_drain();
    // Every pop has handed its credit back by the last response
    check_credit("final credits", OCC_W'(CMD_DEPTH), OCC_W'(credits()));
    $display("all tests passed");
    $finish;
  end

endmodule

/* tests/mpu_spi_trace.txt */
# op a b, hex: W addr data, R addr expected byte, F flood writes from addr with data+i
# C sel value (0 half-period, 1 gap), P expected half-period in clk cycles
R 75 d0
P 4 00
W 1a 03
R 1a 03
W 6b 01
R 6b 01
R 3b 9e
C 0 01
W 23 5c
P 2 00
R 23 5c
C 1 02
W 10 aa
F 40 10
R 40 10
R 43 13
C 0 06
C 1 28
W 19 07
P 6 00
R 19 07
R 42 12
R 7f da
